//--- hdl/core.sv
// ====================
// core
// five-stage RV32 subset pipeline: IF, ID, EX, MEM, WB
// instruction and data memories are external, read combinationally
// ====================
`include "core_defs.svh"

module core (
  input  logic               clk,
  input  logic               rst,
  input  logic               stall,
  output logic [`XLEN-1:0]   im_addr,
  input  logic [`INSTR_W-1:0] im_data,
  output logic               dm_enable,
  output logic               dm_write,
  output logic [`XLEN-1:0]   dm_addr,
  output logic [`XLEN-1:0]   dm_wdata,
  input  logic [`XLEN-1:0]   dm_rdata
);

  core_pkg::if_id_t   if_id_q;
  core_pkg::id_ex_t   id_ex_d;
  core_pkg::id_ex_t   id_ex_q;
  core_pkg::ex_mem_t  ex_mem_q;
  core_pkg::mem_wb_t  mem_wb_q;
  core_pkg::cutset_t  cmd_if_id;
  core_pkg::cutset_t  cmd_id_ex;
  core_pkg::cutset_t  cmd_ex_mem;
  core_pkg::cutset_t  cmd_mem_wb;
  core_pkg::fwd_sel_t fwd_a;
  core_pkg::fwd_sel_t fwd_b;
  core_pkg::alu_op_t  alu_op;

  logic                   pc_hold;
  logic                   branch_taken;
  logic [`XLEN-1:0]       branch_target;
  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`REG_ADDR_W-1:0] rd_addr;
  logic [`XLEN-1:0]       imm;
  logic                   use_imm;
  logic                   is_branch;
  logic                   branch_ne;
  logic                   mem_read;
  logic                   mem_write;
  logic                   reg_write;
  logic                   uses_rs2;
  logic                   gated_mem_write;
  logic                   gated_mem_read;
  logic                   gated_reg_write;
  logic                   gated_is_branch;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;
  logic [`XLEN-1:0]       wb_data;
  logic [`XLEN-1:0]       ex_result;
  logic [`XLEN-1:0]       ex_store_data;

  // ====================
  // IF
  // ====================
  // stall freezes redirects and register writes as well
  fetch_unit u_fetch (
    .clk(clk), .rst(rst), .pc_hold(pc_hold),
    .branch_taken(branch_taken & ~stall), .branch_target(branch_target),
    .pc(im_addr)
  );

  pipe_stage #(.payload_t(core_pkg::if_id_t)) if_id_reg (
    .clk(clk), .rst(rst), .cmd(cmd_if_id),
    .d('{pc: im_addr, instr: im_data}), .q(if_id_q)
  );

  // ====================
  // ID
  // ====================
  decode_unit u_decode (
    .instr(if_id_q.instr), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
    .imm(imm), .alu_op(alu_op), .use_imm(use_imm), .is_branch(is_branch),
    .branch_ne(branch_ne), .mem_read(mem_read), .mem_write(mem_write),
    .reg_write(reg_write), .uses_rs2(uses_rs2)
  );

  regfile u_regfile (
    .clk(clk), .rst(rst), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .wb_reg_write(mem_wb_q.reg_write & ~stall), .wb_rd(mem_wb_q.rd),
    .wb_mem_read(mem_wb_q.mem_read), .wb_result(mem_wb_q.result),
    .wb_load_data(mem_wb_q.load_data), .wb_data(wb_data)
  );

  hazard_unit u_hazard (
    .stall(stall), .branch_taken(branch_taken),
    .id_rs1(rs1_addr), .id_rs2(rs2_addr), .id_uses_rs2(uses_rs2),
    .ex_rs1(id_ex_q.rs1), .ex_rs2(id_ex_q.rs2), .ex_rd(id_ex_q.rd),
    .ex_mem_read(id_ex_q.mem_read), .mem_rd(ex_mem_q.rd), .mem_reg_write(ex_mem_q.reg_write),
    .wb_rd(mem_wb_q.rd), .wb_reg_write(mem_wb_q.reg_write),
    .id_mem_write(mem_write), .id_mem_read(mem_read), .id_reg_write(reg_write),
    .id_is_branch(is_branch), .gated_mem_write(gated_mem_write),
    .gated_mem_read(gated_mem_read), .gated_reg_write(gated_reg_write),
    .gated_is_branch(gated_is_branch), .fwd_a(fwd_a), .fwd_b(fwd_b),
    .cmd_if_id(cmd_if_id), .cmd_id_ex(cmd_id_ex), .cmd_ex_mem(cmd_ex_mem),
    .cmd_mem_wb(cmd_mem_wb), .pc_hold(pc_hold)
  );

  assign id_ex_d = '{pc: if_id_q.pc, rs1_val: rs1_data, rs2_val: rs2_data,
                     rs1: rs1_addr, rs2: rs2_addr, rd: rd_addr, imm: imm,
                     alu_op: alu_op, use_imm: use_imm, is_branch: gated_is_branch,
                     branch_ne: branch_ne, mem_read: gated_mem_read,
                     mem_write: gated_mem_write, reg_write: gated_reg_write};

  pipe_stage #(.payload_t(core_pkg::id_ex_t)) id_ex_reg (
    .clk(clk), .rst(rst), .cmd(cmd_id_ex), .d(id_ex_d), .q(id_ex_q)
  );

  // ====================
  // EX
  // ====================
  execute_unit u_execute (
    .rs1_val(id_ex_q.rs1_val), .rs2_val(id_ex_q.rs2_val), .imm(id_ex_q.imm),
    .pc(id_ex_q.pc), .alu_op(id_ex_q.alu_op), .use_imm(id_ex_q.use_imm),
    .is_branch(id_ex_q.is_branch), .branch_ne(id_ex_q.branch_ne),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_result(ex_mem_q.result), .wb_data(wb_data),
    .result(ex_result), .store_data(ex_store_data),
    .branch_taken(branch_taken), .branch_target(branch_target)
  );

  pipe_stage #(.payload_t(core_pkg::ex_mem_t)) ex_mem_reg (
    .clk(clk), .rst(rst), .cmd(cmd_ex_mem),
    .d('{result: ex_result, store_data: ex_store_data, rd: id_ex_q.rd,
         mem_read: id_ex_q.mem_read, mem_write: id_ex_q.mem_write,
         reg_write: id_ex_q.reg_write}),
    .q(ex_mem_q)
  );

  // ====================
  // MEM / WB
  // ====================
  assign dm_enable = ex_mem_q.mem_read | ex_mem_q.mem_write;
  assign dm_write  = ex_mem_q.mem_write;
  assign dm_addr   = ex_mem_q.result;
  assign dm_wdata  = ex_mem_q.store_data;

  pipe_stage #(.payload_t(core_pkg::mem_wb_t)) mem_wb_reg (
    .clk(clk), .rst(rst), .cmd(cmd_mem_wb),
    .d('{result: ex_mem_q.result, load_data: dm_rdata, rd: ex_mem_q.rd,
         mem_read: ex_mem_q.mem_read, reg_write: ex_mem_q.reg_write}),
    .q(mem_wb_q)
  );

endmodule

//--- hdl/core_defs.svh
// ====================
// core_defs
// widths, opcodes and funct3 codes for the RV32 integer subset
// ====================
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath widths
`define XLEN        32
`define REG_ADDR_W  5
`define INSTR_W     32
`define REG_COUNT   32

// major opcodes
`define OP_RTYPE    7'b0110011
`define OP_ITYPE    7'b0010011
`define OP_LUI      7'b0110111
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011

// funct3 for alu and branch groups
`define F3_ADD      3'b000
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_BEQ      3'b000
`define F3_BNE      3'b001

`endif

//--- hdl/core_pkg.sv
// ====================
// core_pkg
// control enums and the four pipeline stage payloads
// ====================
`include "core_defs.svh"

package core_pkg;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b
  } alu_op_t;

  // command for one pipeline register
  typedef enum logic [1:0] {cut_flush, cut_hold, cut_push} cutset_t;

  typedef enum logic [1:0] {fwd_regfile, fwd_mem, fwd_wb} fwd_sel_t;

  typedef struct packed {
    logic [`XLEN-1:0]    pc;
    logic [`INSTR_W-1:0] instr;
  } if_id_t;

  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       rs1_val;
    logic [`XLEN-1:0]       rs2_val;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       imm;
    alu_op_t                alu_op;
    logic                   use_imm;
    logic                   is_branch;
    logic                   branch_ne;
    logic                   mem_read;
    logic                   mem_write;
    logic                   reg_write;
  } id_ex_t;

  typedef struct packed {
    logic [`XLEN-1:0]       result;
    logic [`XLEN-1:0]       store_data;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   mem_read;
    logic                   mem_write;
    logic                   reg_write;
  } ex_mem_t;

  typedef struct packed {
    logic [`XLEN-1:0]       result;
    logic [`XLEN-1:0]       load_data;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   mem_read;
    logic                   reg_write;
  } mem_wb_t;

endpackage

//--- hdl/decode_unit.sv
// ====================
// decode_unit
// splits fields, builds the immediate and derives control bits
// unknown encodings decode as a no-op
// ====================
`include "core_defs.svh"

module decode_unit (
  input  logic [`INSTR_W-1:0]    instr,
  output logic [`REG_ADDR_W-1:0] rs1_addr,
  output logic [`REG_ADDR_W-1:0] rs2_addr,
  output logic [`REG_ADDR_W-1:0] rd_addr,
  output logic [`XLEN-1:0]       imm,
  output core_pkg::alu_op_t      alu_op,
  output logic                   use_imm,
  output logic                   is_branch,
  output logic                   branch_ne,
  output logic                   mem_read,
  output logic                   mem_write,
  output logic                   reg_write,
  output logic                   uses_rs2
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic              funct7_5;
  logic [`XLEN-1:0]  imm_i;
  logic [`XLEN-1:0]  imm_s;
  logic [`XLEN-1:0]  imm_b;
  logic [`XLEN-1:0]  imm_u;
  core_pkg::alu_op_t f3_op;
  logic              f3_ok;

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7_5 = instr[30];
  assign rd_addr  = instr[11:7];
  assign rs2_addr = instr[24:20];
  // lui carries immediate bits in the rs1 field
  assign rs1_addr = (opcode == `OP_LUI) ? '0 : instr[19:15];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  // funct3 map shared by register and immediate forms
  always_comb begin
    f3_ok = 1'b1;
    case (funct3)
      `F3_ADD: f3_op = core_pkg::alu_add;
      `F3_SLT: f3_op = core_pkg::alu_slt;
      `F3_XOR: f3_op = core_pkg::alu_xor;
      `F3_OR:  f3_op = core_pkg::alu_or;
      `F3_AND: f3_op = core_pkg::alu_and;
      default: begin
        f3_op = core_pkg::alu_add;
        f3_ok = 1'b0;
      end
    endcase
  end

  always_comb begin
    imm       = '0;
    alu_op    = core_pkg::alu_add;
    use_imm   = 1'b0;
    is_branch = 1'b0;
    branch_ne = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    uses_rs2  = 1'b0;
    case (opcode)
      `OP_RTYPE: begin
        uses_rs2  = 1'b1;
        reg_write = f3_ok;
        alu_op    = (funct3 == `F3_ADD && funct7_5) ? core_pkg::alu_sub : f3_op;
      end
      `OP_ITYPE: begin
        imm       = imm_i;
        use_imm   = 1'b1;
        reg_write = f3_ok;
        alu_op    = f3_op;
      end
      `OP_LUI: begin
        imm       = imm_u;
        use_imm   = 1'b1;
        reg_write = 1'b1;
        alu_op    = core_pkg::alu_pass_b;
      end
      `OP_LOAD: begin
        imm       = imm_i;
        use_imm   = 1'b1;
        mem_read  = 1'b1;
        reg_write = 1'b1;
      end
      `OP_STORE: begin
        imm       = imm_s;
        use_imm   = 1'b1;
        mem_write = 1'b1;
        uses_rs2  = 1'b1;
      end
      `OP_BRANCH: begin
        imm       = imm_b;
        uses_rs2  = 1'b1;
        is_branch = (funct3 == `F3_BEQ) || (funct3 == `F3_BNE);
        branch_ne = (funct3 == `F3_BNE);
      end
      default: ;
    endcase
  end

endmodule

//--- hdl/execute_unit.sv
// ====================
// execute_unit
// operand forwarding, ALU, branch compare and target
// ====================
`include "core_defs.svh"

module execute_unit (
  input  logic [`XLEN-1:0]   rs1_val,
  input  logic [`XLEN-1:0]   rs2_val,
  input  logic [`XLEN-1:0]   imm,
  input  logic [`XLEN-1:0]   pc,
  input  core_pkg::alu_op_t  alu_op,
  input  logic               use_imm,
  input  logic               is_branch,
  input  logic               branch_ne,
  input  core_pkg::fwd_sel_t fwd_a,
  input  core_pkg::fwd_sel_t fwd_b,
  input  logic [`XLEN-1:0]   mem_result,
  input  logic [`XLEN-1:0]   wb_data,
  output logic [`XLEN-1:0]   result,
  output logic [`XLEN-1:0]   store_data,
  output logic               branch_taken,
  output logic [`XLEN-1:0]   branch_target
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b_reg;
  logic [`XLEN-1:0] op_b;

  function automatic logic [`XLEN-1:0] fwd_mux(input core_pkg::fwd_sel_t sel,
                                               input logic [`XLEN-1:0] reg_val);
    case (sel)
      core_pkg::fwd_mem: return mem_result;
      core_pkg::fwd_wb:  return wb_data;
      default:           return reg_val;
    endcase
  endfunction

  always_comb begin
    op_a     = fwd_mux(fwd_a, rs1_val);
    op_b_reg = fwd_mux(fwd_b, rs2_val);
  end

  assign op_b       = use_imm ? imm : op_b_reg;
  assign store_data = op_b_reg;

  always_comb begin
    case (alu_op)
      core_pkg::alu_sub:    result = op_a - op_b;
      core_pkg::alu_and:    result = op_a & op_b;
      core_pkg::alu_or:     result = op_a | op_b;
      core_pkg::alu_xor:    result = op_a ^ op_b;
      core_pkg::alu_slt:    result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      core_pkg::alu_pass_b: result = op_b;
      default:              result = op_a + op_b;
    endcase
  end

  // beq / bne on the forwarded register values
  assign branch_taken  = is_branch & ((op_a == op_b_reg) ^ branch_ne);
  assign branch_target = pc + imm;

endmodule

//--- hdl/fetch_unit.sv
// ====================
// fetch_unit
// program counter, holds on stall or load-use, redirects on branch
// ====================
`include "core_defs.svh"

module fetch_unit (
  input  logic             clk,
  input  logic             rst,
  input  logic             pc_hold,
  input  logic             branch_taken,
  input  logic [`XLEN-1:0] branch_target,
  output logic [`XLEN-1:0] pc
);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (branch_taken) begin
      // redirect wins over hold
      pc <= branch_target;
    end else if (!pc_hold) begin
      pc <= pc + `XLEN'd4;
    end
  end

  // branch targets come from execute, so alignment is checked here
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("fetch_unit: misaligned pc %h", pc);

endmodule

//--- hdl/hazard_unit.sv
// ====================
// hazard_unit
// stall/flush priority, load-use bubble and EX forward selects
// ====================
`include "core_defs.svh"

module hazard_unit (
  input  logic                   stall,
  input  logic                   branch_taken,
  input  logic [`REG_ADDR_W-1:0] id_rs1,
  input  logic [`REG_ADDR_W-1:0] id_rs2,
  input  logic                   id_uses_rs2,
  input  logic [`REG_ADDR_W-1:0] ex_rs1,
  input  logic [`REG_ADDR_W-1:0] ex_rs2,
  input  logic [`REG_ADDR_W-1:0] ex_rd,
  input  logic                   ex_mem_read,
  input  logic [`REG_ADDR_W-1:0] mem_rd,
  input  logic                   mem_reg_write,
  input  logic [`REG_ADDR_W-1:0] wb_rd,
  input  logic                   wb_reg_write,
  input  logic                   id_mem_write,
  input  logic                   id_mem_read,
  input  logic                   id_reg_write,
  input  logic                   id_is_branch,
  output logic                   gated_mem_write,
  output logic                   gated_mem_read,
  output logic                   gated_reg_write,
  output logic                   gated_is_branch,
  output core_pkg::fwd_sel_t     fwd_a,
  output core_pkg::fwd_sel_t     fwd_b,
  output core_pkg::cutset_t      cmd_if_id,
  output core_pkg::cutset_t      cmd_id_ex,
  output core_pkg::cutset_t      cmd_ex_mem,
  output core_pkg::cutset_t      cmd_mem_wb,
  output logic                   pc_hold
);

  logic load_use;

  // newest producer wins, x0 never forwards
  function automatic core_pkg::fwd_sel_t pick_src(input logic [`REG_ADDR_W-1:0] src);
    if (src == '0) return core_pkg::fwd_regfile;
    if (mem_reg_write && mem_rd == src) return core_pkg::fwd_mem;
    if (wb_reg_write && wb_rd == src) return core_pkg::fwd_wb;
    return core_pkg::fwd_regfile;
  endfunction

  always_comb begin
    fwd_a = pick_src(ex_rs1);
    fwd_b = pick_src(ex_rs2);
  end

  assign load_use = ex_mem_read && (ex_rd != '0) &&
                    ((ex_rd == id_rs1) || (id_uses_rs2 && ex_rd == id_rs2));

  // bubble: the held ID instruction enters EX with no side effects
  assign gated_mem_write = id_mem_write & ~load_use;
  assign gated_mem_read  = id_mem_read & ~load_use;
  assign gated_reg_write = id_reg_write & ~load_use;
  assign gated_is_branch = id_is_branch & ~load_use;

  // ====================
  // command priority
  // ====================
  always_comb begin
    cmd_if_id  = core_pkg::cut_push;
    cmd_id_ex  = core_pkg::cut_push;
    cmd_ex_mem = core_pkg::cut_push;
    cmd_mem_wb = core_pkg::cut_push;
    pc_hold    = 1'b0;
    if (stall) begin
      cmd_if_id  = core_pkg::cut_hold;
      cmd_id_ex  = core_pkg::cut_hold;
      cmd_ex_mem = core_pkg::cut_hold;
      cmd_mem_wb = core_pkg::cut_hold;
      pc_hold    = 1'b1;
    end else if (branch_taken) begin
      // kill the two younger slots
      cmd_if_id = core_pkg::cut_flush;
      cmd_id_ex = core_pkg::cut_flush;
    end else if (load_use) begin
      cmd_if_id = core_pkg::cut_hold;
      pc_hold   = 1'b1;
    end
  end

endmodule

//--- hdl/pipe_stage.sv
// ====================
// pipe_stage
// pipeline register with flush, hold and push
// shared by all four stage boundaries
// ====================
module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic              clk,
  input  logic              rst,
  input  core_pkg::cutset_t cmd,
  input  payload_t          d,
  output payload_t          q
);

  always_ff @(posedge clk) begin
    if (rst) begin
      q <= '0;
    end else begin
      case (cmd)
        core_pkg::cut_flush: q <= '0;
        core_pkg::cut_push:  q <= d;
        default:             q <= q;
      endcase
    end
  end

  // hazard unit must only issue the three defined commands
  a_cmd_legal: assert property (@(posedge clk) disable iff (rst)
    cmd inside {core_pkg::cut_flush, core_pkg::cut_hold, core_pkg::cut_push})
    else $error("pipe_stage: illegal command %0d", cmd);

endmodule

//--- hdl/regfile.sv
// ====================
// regfile
// 32 x XLEN registers, x0 reads zero, write-through on read
// ====================
`include "core_defs.svh"

module regfile (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`REG_ADDR_W-1:0] rs1_addr,
  input  logic [`REG_ADDR_W-1:0] rs2_addr,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data,
  input  logic                   wb_reg_write,
  input  logic [`REG_ADDR_W-1:0] wb_rd,
  input  logic                   wb_mem_read,
  input  logic [`XLEN-1:0]       wb_result,
  input  logic [`XLEN-1:0]       wb_load_data,
  output logic [`XLEN-1:0]       wb_data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];
  logic             write_en;

  function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
    if (addr == '0) return '0;
    // bypass the value landing this cycle
    if (write_en && addr == wb_rd) return wb_data;
    return regs[addr];
  endfunction

  assign wb_data  = wb_mem_read ? wb_load_data : wb_result;
  assign write_en = wb_reg_write && (wb_rd != '0);

  always_ff @(posedge clk) begin
    if (!rst && write_en) begin
      regs[wb_rd] <= wb_data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

endmodule

//--- run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it, and fail on the fail message in sim.log.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --assert -Wno-fatal --top-module core_tb -f verilog.f \
    -o core_sim > build.log 2>&1 &&
  ./obj_dir/core_sim > sim.log 2>&1 &&
  ! grep -q "=== FAIL ===" sim.log &&
  echo "simulation passed" ||
  { cat build.log sim.log; echo "simulation failed"; exit 1; }

//--- verif/core_tb.sv
// ====================
// core_tb
// runs the test program on the pipelined core and checks stores,
// reset state, stall hold and fetch order with assertions
// ====================
`include "core_defs.svh"

module core_tb;

  localparam int PROG_LEN     = 31;
  localparam int NUM_STORES   = 7;
  localparam int STALL_START  = 20;
  localparam int STALL_WINDOW = 60;
  // three passes over the program plus every cycle the lfsr may stall
  localparam int TIMEOUT      = 3 * PROG_LEN + STALL_WINDOW;
  localparam logic [`XLEN-1:0] POISON_ADDR = 32'h1fc;
  localparam logic [`XLEN-1:0] DONE_ADDR   = 32'h100;

  logic                clk;
  logic                rst;
  logic                stall;
  logic [`XLEN-1:0]    im_addr;
  logic [`INSTR_W-1:0] im_data;
  logic                dm_enable;
  logic                dm_write;
  logic [`XLEN-1:0]    dm_addr;
  logic [`XLEN-1:0]    dm_wdata;
  logic [`XLEN-1:0]    dm_rdata;

  int         errors = 0;
  int         store_idx = 0;
  int         cycle = 0;
  logic       done = 1'b0;
  logic [7:0] lfsr;
  logic       last_bit;

  core DUT (
    .clk(clk), .rst(rst), .stall(stall), .im_addr(im_addr), .im_data(im_data),
    .dm_enable(dm_enable), .dm_write(dm_write), .dm_addr(dm_addr),
    .dm_wdata(dm_wdata), .dm_rdata(dm_rdata)
  );

  tb_memory #(.NUM_STORES(NUM_STORES)) mem (
    .clk(clk), .stall(stall), .im_addr(im_addr), .im_data(im_data),
    .dm_write(dm_write), .dm_addr(dm_addr), .dm_wdata(dm_wdata), .dm_rdata(dm_rdata)
  );

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  always #5 clk = ~clk;

  // stores count only on edges where the memory really writes
  always @(posedge clk) begin
    if (rst) begin
      store_idx <= 0;
      done      <= 1'b0;
    end else if (dm_write && !stall) begin
      store_idx <= store_idx + 1;
      if (dm_addr == DONE_ADDR) begin
        done <= 1'b1;
      end
    end
  end

  // ====================
  // assertions
  // ====================
  a_reset_quiet: assert property (@(posedge clk)
    ($past(rst) || $past(rst, 2)) |-> (!dm_enable && !dm_write))
    else begin
      errors++;
      $display("reset: data memory strobe active during or right after reset");
    end

  a_first_fetch: assert property (@(posedge clk) (!rst && $past(rst)) |-> im_addr == '0)
    else begin
      errors++;
      $display("mismatch first_fetch: expected %h actual %h", 32'h0, $sampled(im_addr));
    end

  a_store_addr: assert property (@(posedge clk) disable iff (rst)
    (dm_write && !stall && store_idx < NUM_STORES) |-> dm_addr == mem.exp_addr[store_idx])
    else begin
      errors++;
      $display("mismatch store %0d addr: expected %h actual %h", $sampled(store_idx),
               mem.exp_addr[$sampled(store_idx)], $sampled(dm_addr));
    end

  a_store_data: assert property (@(posedge clk) disable iff (rst)
    (dm_write && !stall && store_idx < NUM_STORES) |-> dm_wdata == mem.exp_data[store_idx])
    else begin
      errors++;
      $display("mismatch store %0d data: expected %h actual %h", $sampled(store_idx),
               mem.exp_data[$sampled(store_idx)], $sampled(dm_wdata));
    end

  // a store is also a data memory access
  a_store_enable: assert property (@(posedge clk) disable iff (rst)
    dm_write |-> dm_enable)
    else begin
      errors++;
      $display("data memory write to %h without the access strobe", $sampled(dm_addr));
    end

  a_no_extra: assert property (@(posedge clk) disable iff (rst)
    (dm_write && !stall) |-> store_idx < NUM_STORES)
    else begin
      errors++;
      $display("extra store to %h after all expected stores", $sampled(dm_addr));
    end

  a_no_poison: assert property (@(posedge clk) disable iff (rst)
    !(dm_write && dm_addr == POISON_ADDR))
    else begin
      errors++;
      $display("store from a skipped instruction reached the data memory");
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    (!$past(rst) && $past(stall)) |-> (dm_addr == $past(dm_addr) &&
      dm_wdata == $past(dm_wdata) && dm_write == $past(dm_write) &&
      im_addr == $past(im_addr)))
    else begin
      errors++;
      $display("outputs changed while stall was high");
    end

  // step by 4, hold, or jump to a listed branch target
  a_fetch_step: assert property (@(posedge clk) disable iff (rst)
    (!$past(rst) && !$past(stall)) |-> (im_addr == $past(im_addr) + 4 ||
      im_addr == $past(im_addr) || im_addr == mem.targets[0] || im_addr == mem.targets[1]))
    else begin
      errors++;
      $display("fetch address went from %h to %h", $past(im_addr), $sampled(im_addr));
    end

  a_hold_once: assert property (@(posedge clk) disable iff (rst)
    (!$past(rst) && !$past(stall) && im_addr == $past(im_addr)) |->
      ($past(im_addr) != $past(im_addr, 2) || $past(stall, 2) || $past(rst, 2)))
    else begin
      errors++;
      $display("fetch held for more than one edge without stall");
    end

  // ====================
  // stimulus and report
  // ====================
  initial begin
    logic bit_now;
    clk      = 1'b0;
    rst      = 1'b1;
    stall    = 1'b0;
    lfsr     = 8'd51;
    last_bit = 1'b0;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    while (!done && cycle < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycle++;
      // second half: stall on two set bits in a row
      if (cycle >= STALL_START && cycle < STALL_START + STALL_WINDOW) begin
        bit_now  = lfsr[7];
        lfsr     = lfsr_next(lfsr);
        stall    = bit_now & last_bit;
        last_bit = bit_now;
      end else begin
        stall = 1'b0;
      end
    end
    stall = 1'b0;
    repeat (2) @(posedge clk);
    if (!done) begin
      errors++;
      $display("timeout: final store not seen within %0d cycles", TIMEOUT);
    end
    if (store_idx != NUM_STORES) begin
      errors++;
      $display("store count wrong: saw %0d stores, table lists %0d", store_idx, NUM_STORES);
    end
    $display("summary: %0d errors, %0d of %0d stores, %0d cycles",
             errors, store_idx, NUM_STORES, cycle);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- verif/tb_memory.sv
// ====================
// tb_memory
// instruction ROM holding the test program, data RAM,
// and the table of stores the program must produce
// ====================
`include "core_defs.svh"

module tb_memory #(
  parameter int NUM_STORES = 7
) (
  input  logic                clk,
  input  logic                stall,
  input  logic [`XLEN-1:0]    im_addr,
  output logic [`INSTR_W-1:0] im_data,
  input  logic                dm_write,
  input  logic [`XLEN-1:0]    dm_addr,
  input  logic [`XLEN-1:0]    dm_wdata,
  output logic [`XLEN-1:0]    dm_rdata
);

  localparam int ROM_WORDS = 32;
  localparam int RAM_WORDS = 256;
  // addi x0, x0, 0
  localparam logic [`INSTR_W-1:0] NOP = 32'h0000_0013;

  logic [`INSTR_W-1:0] rom [ROM_WORDS];
  logic [`XLEN-1:0]    ram [RAM_WORDS];
  logic [`XLEN-1:0]    exp_addr [NUM_STORES];
  logic [`XLEN-1:0]    exp_data [NUM_STORES];
  logic [`XLEN-1:0]    targets [2];

  // ====================
  // encoders
  // ====================
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OP_RTYPE};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {off[11:5], rs2, rs1, 3'b010, off[4:0], `OP_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, `OP_LUI};
  endfunction

  // every bit of the byte address shows up in the word
  function automatic logic [31:0] fill_word(input logic [31:0] byte_addr);
    return 32'hc0de_0000 ^ {byte_addr[15:0], byte_addr[15:0]};
  endfunction

  initial begin
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = NOP;
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
      ram[i] = fill_word(i * 4);
    end
    // dependent alu chain
    rom[0]  = i_type(12'd5, 5'd0, `F3_ADD, 5'd1, `OP_ITYPE);
    rom[1]  = i_type(12'd7, 5'd1, `F3_ADD, 5'd2, `OP_ITYPE);
    rom[2]  = r_type(7'h00, 5'd2, 5'd1, `F3_ADD, 5'd3);
    rom[3]  = r_type(7'h20, 5'd1, 5'd3, `F3_ADD, 5'd4);
    rom[4]  = s_type(12'h080, 5'd4, 5'd0);
    rom[5]  = u_type(20'h12345, 5'd5);
    rom[6]  = i_type(12'h678, 5'd5, `F3_OR, 5'd6, `OP_ITYPE);
    rom[7]  = r_type(7'h00, 5'd3, 5'd6, `F3_XOR, 5'd7);
    rom[8]  = s_type(12'h084, 5'd7, 5'd0);
    rom[9]  = r_type(7'h00, 5'd6, 5'd4, `F3_SLT, 5'd8);
    rom[10] = i_type(12'h0ff, 5'd6, `F3_AND, 5'd9, `OP_ITYPE);
    rom[11] = r_type(7'h00, 5'd9, 5'd8, `F3_OR, 5'd10);
    rom[12] = s_type(12'h088, 5'd10, 5'd0);
    rom[13] = i_type(12'hffd, 5'd0, `F3_ADD, 5'd11, `OP_ITYPE);
    rom[14] = i_type(12'hffe, 5'd11, `F3_SLT, 5'd12, `OP_ITYPE);
    rom[15] = r_type(7'h00, 5'd7, 5'd6, `F3_AND, 5'd13);
    rom[16] = r_type(7'h20, 5'd12, 5'd13, `F3_ADD, 5'd14);
    rom[17] = s_type(12'h08c, 5'd14, 5'd0);
    // load then immediate use
    rom[18] = i_type(12'h040, 5'd0, 3'b010, 5'd15, `OP_LOAD);
    rom[19] = r_type(7'h00, 5'd1, 5'd15, `F3_ADD, 5'd16);
    rom[20] = s_type(12'h090, 5'd16, 5'd0);
    // taken beq and bne, each skipping two poison stores
    rom[21] = b_type(13'd12, 5'd2, 5'd4, `F3_BEQ);
    rom[22] = s_type(12'h1fc, 5'd1, 5'd0);
    rom[23] = s_type(12'h1fc, 5'd2, 5'd0);
    rom[24] = b_type(13'd12, 5'd2, 5'd1, `F3_BNE);
    rom[25] = s_type(12'h1fc, 5'd1, 5'd0);
    rom[26] = s_type(12'h1fc, 5'd2, 5'd0);
    // not taken, falls through to the store
    rom[27] = b_type(13'd8, 5'd2, 5'd4, `F3_BNE);
    rom[28] = s_type(12'h094, 5'd3, 5'd0);
    rom[29] = i_type(12'h05a, 5'd0, `F3_ADD, 5'd17, `OP_ITYPE);
    rom[30] = s_type(12'h100, 5'd17, 5'd0);

    exp_addr[0] = 32'h080;
    exp_data[0] = 32'd12;
    exp_addr[1] = 32'h084;
    exp_data[1] = 32'h1234_5669;
    exp_addr[2] = 32'h088;
    exp_data[2] = 32'h79;
    exp_addr[3] = 32'h08c;
    exp_data[3] = 32'h1234_5667;
    exp_addr[4] = 32'h090;
    exp_data[4] = fill_word(32'h040) + 32'd5;
    exp_addr[5] = 32'h094;
    exp_data[5] = 32'd17;
    exp_addr[6] = 32'h100;
    exp_data[6] = 32'h5a;

    // byte addresses of the two taken branches
    targets[0] = 32'h60;
    targets[1] = 32'h6c;
  end

  assign im_data  = (im_addr[`XLEN-1:2] < ROM_WORDS) ? rom[im_addr[6:2]] : NOP;
  assign dm_rdata = ram[dm_addr[9:2]];

  always @(posedge clk) begin
    if (dm_write && !stall) begin
      ram[dm_addr[9:2]] <= dm_wdata;
    end
  end

endmodule

//--- verilog.f
+incdir+hdl
hdl/core_pkg.sv
hdl/pipe_stage.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/regfile.sv
hdl/hazard_unit.sv
hdl/execute_unit.sv
hdl/core.sv
verif/tb_memory.sv
verif/core_tb.sv
